// ==== rtl/hub75_pkg.sv ====
package hub75_pkg;

    localparam int PIXEL_WIDTH = 16;        // columns per row
    localparam int PIXEL_HEIGHT = 8;        // rows, top and bottom half scanned together
    localparam int BYTES_PER_PIXEL = 2;     // rgb565, high byte first
    localparam int BRIGHTNESS_LEVELS = 5;   // number of bit planes
    localparam int CTRL_TICKS_PER_BIT = 8;  // uart bit length in clocks
    localparam int SCAN_DIV = 4;            // clocks per scan tick
    localparam int OE_BASE_TICKS = 2;       // plane 0 on-time, doubles per plane

    typedef logic [15:0] pixel_t;
    typedef logic [2:0] rgb_t;              // {red, green, blue}
    typedef logic [$clog2(BRIGHTNESS_LEVELS)-1:0] plane_t;

    // host command bytes
    typedef enum logic [7:0] {
        OP_SET_RGB        = 8'h72,
        OP_SET_BRIGHTNESS = 8'h62,
        OP_LOAD_FRAME     = 8'h4c
    } ctrl_opcode_t;

    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_ARG,     // waiting for the argument byte
        CTRL_LOAD
    } ctrl_state_t;

    typedef enum logic [1:0] {
        SCAN_SHIFT,
        SCAN_LATCH,
        SCAN_DISPLAY
    } scan_state_t;

endpackage

// ==== rtl/fetch_if.sv ====
`timescale 1ns/1ps
interface fetch_if import hub75_pkg::*; #(
    parameter int PIXEL_WIDTH = hub75_pkg::PIXEL_WIDTH,
    parameter int PIXEL_HEIGHT = hub75_pkg::PIXEL_HEIGHT
);
    logic [$clog2(PIXEL_WIDTH)-1:0] column_address;
    logic [$clog2(PIXEL_HEIGHT / 2)-1:0] row_address;  // row in the top half
    plane_t plane;
    logic load_start;   // one-clock request
    rgb_t rgb_top;
    rgb_t rgb_bottom;
    logic data_valid;   // one-clock, three clocks after load_start

    modport scan (
        output column_address, row_address, plane, load_start,
        input  rgb_top, rgb_bottom, data_valid
    );

    modport fetch (
        input  column_address, row_address, plane, load_start,
        output rgb_top, rgb_bottom, data_valid
    );

endinterface

// ==== rtl/uart_rx.sv ====
`timescale 1ns/1ps
module uart_rx import hub75_pkg::*; #(
    parameter int TICKS_PER_BIT = CTRL_TICKS_PER_BIT
) (
    input  logic       clk_in,
    input  logic       reset,
    input  logic       rx,
    output logic [7:0] rx_data,
    output logic       rx_valid
);
    localparam int CW = $clog2(TICKS_PER_BIT);
    localparam logic [CW-1:0] FULL_BIT = CW'(TICKS_PER_BIT - 1);
    localparam logic [CW-1:0] HALF_BIT = CW'(TICKS_PER_BIT / 2 - 1);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t state;
    logic [1:0] rx_sync;          // two flops, line idles high
    logic [CW-1:0] tick_count;
    logic [2:0] bit_index;
    logic rx_bit;

    assign rx_bit = rx_sync[1];

    always_ff @(posedge clk_in) begin
        if (reset) begin
            rx_sync <= 2'b11;
            state <= RX_IDLE;
            tick_count <= '0;
            bit_index <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_sync <= {rx_sync[0], rx};
            rx_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    tick_count <= '0;
                    if (!rx_bit)
                        state <= RX_START;
                end
                RX_START: begin
                    if (tick_count == HALF_BIT) begin  // middle of start bit
                        tick_count <= '0;
                        bit_index <= '0;
                        state <= rx_bit ? RX_IDLE : RX_DATA;  // high again means a glitch
                    end else begin
                        tick_count <= tick_count + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (tick_count == FULL_BIT) begin
                        tick_count <= '0;
                        rx_data <= {rx_bit, rx_data[7:1]};  // lsb arrives first
                        bit_index <= bit_index + 1'b1;
                        if (bit_index == 3'd7)
                            state <= RX_STOP;
                    end else begin
                        tick_count <= tick_count + 1'b1;
                    end
                end
                default: begin
                    // stop bit, a low line here drops the byte
                    if (tick_count == FULL_BIT) begin
                        rx_valid <= rx_bit;
                        state <= RX_IDLE;
                    end else begin
                        tick_count <= tick_count + 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

// ==== rtl/control_module.sv ====
`timescale 1ns/1ps
module control_module import hub75_pkg::*; #(
    parameter int PIXEL_WIDTH = hub75_pkg::PIXEL_WIDTH,
    parameter int PIXEL_HEIGHT = hub75_pkg::PIXEL_HEIGHT
) (
    input  logic clk_in,
    input  logic reset,
    input  logic [7:0] rx_data,
    input  logic rx_valid,
    output logic [$clog2(PIXEL_WIDTH * PIXEL_HEIGHT * BYTES_PER_PIXEL)-1:0] wr_address,
    output logic [7:0] wr_data,
    output logic wr_enable,
    output rgb_t rgb_enable,
    output logic [BRIGHTNESS_LEVELS-1:0] brightness_enable
);
    localparam int FRAME_BYTES = PIXEL_WIDTH * PIXEL_HEIGHT * BYTES_PER_PIXEL;
    localparam int ADDR_BITS = $clog2(FRAME_BYTES);
    localparam logic [ADDR_BITS-1:0] LAST_BYTE = ADDR_BITS'(FRAME_BYTES - 1);

    ctrl_state_t state;
    ctrl_opcode_t opcode;               // command that owns the next byte
    logic [ADDR_BITS-1:0] byte_count;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state <= CTRL_IDLE;
            opcode <= OP_SET_RGB;
            byte_count <= '0;
            wr_enable <= 1'b0;
            rgb_enable <= 3'b111;
            brightness_enable <= '1;
        end else begin
            wr_enable <= 1'b0;
            if (rx_valid) begin
                case (state)
                    CTRL_IDLE: begin
                        case (rx_data)
                            OP_SET_RGB, OP_SET_BRIGHTNESS: begin
                                opcode <= ctrl_opcode_t'(rx_data);
                                state <= CTRL_ARG;
                            end
                            OP_LOAD_FRAME: begin
                                byte_count <= '0;
                                state <= CTRL_LOAD;
                            end
                            default: ;  // unknown byte, stay idle
                        endcase
                    end
                    CTRL_ARG: begin
                        if (opcode == OP_SET_RGB)
                            rgb_enable <= rx_data[2:0];
                        else
                            brightness_enable <= rx_data[BRIGHTNESS_LEVELS-1:0];
                        state <= CTRL_IDLE;
                    end
                    default: begin
                        // frame load, byte k lands at address k
                        wr_address <= byte_count;
                        wr_data <= rx_data;
                        wr_enable <= 1'b1;
                        byte_count <= byte_count + 1'b1;
                        if (byte_count == LAST_BYTE)
                            state <= CTRL_IDLE;
                    end
                endcase
            end
        end
    end

endmodule

// ==== rtl/framebuffer_ram.sv ====
`timescale 1ns/1ps
module framebuffer_ram import hub75_pkg::*; #(
    parameter int PIXEL_WIDTH = hub75_pkg::PIXEL_WIDTH,
    parameter int PIXEL_HEIGHT = hub75_pkg::PIXEL_HEIGHT
) (
    input  logic clk_in,
    input  logic [$clog2(PIXEL_WIDTH * PIXEL_HEIGHT * BYTES_PER_PIXEL)-1:0] wr_address,
    input  logic [7:0] wr_data,
    input  logic wr_enable,
    input  logic [$clog2(PIXEL_WIDTH * PIXEL_HEIGHT)-1:0] rd_address,
    input  logic rd_enable,
    output pixel_t rd_data
);
    localparam int PIXELS = PIXEL_WIDTH * PIXEL_HEIGHT;
    localparam int ADDR_BITS = $clog2(PIXELS * BYTES_PER_PIXEL);

    pixel_t mem [PIXELS];

    always_ff @(posedge clk_in) begin
        if (wr_enable) begin
            if (wr_address[0])
                mem[wr_address[ADDR_BITS-1:1]][7:0] <= wr_data;   // second byte is low
            else
                mem[wr_address[ADDR_BITS-1:1]][15:8] <= wr_data;
        end
        if (rd_enable)
            rd_data <= mem[rd_address];
    end

endmodule

// ==== rtl/framebuffer_fetch.sv ====
`timescale 1ns/1ps
module framebuffer_fetch import hub75_pkg::*; #(
    parameter int PIXEL_WIDTH = hub75_pkg::PIXEL_WIDTH,
    parameter int PIXEL_HEIGHT = hub75_pkg::PIXEL_HEIGHT
) (
    input  logic clk_in,
    input  logic reset,
    fetch_if.fetch fetch,
    output logic [$clog2(PIXEL_WIDTH * PIXEL_HEIGHT)-1:0] rd_address,
    output logic rd_enable,
    input  pixel_t rd_data,
    input  rgb_t rgb_enable,
    input  logic [BRIGHTNESS_LEVELS-1:0] brightness_enable
);
    localparam int PIX_BITS = $clog2(PIXEL_WIDTH * PIXEL_HEIGHT);
    localparam int HALF_OFFSET = PIXEL_HEIGHT / 2 * PIXEL_WIDTH;

    logic [PIX_BITS-1:0] top_index;
    logic [PIX_BITS-1:0] bottom_index;
    logic bottom_pending;   // bottom read goes out this clock
    logic top_ready;        // top pixel held, bottom on rd_data
    pixel_t top_pixel;

    // one bit per colour for this plane, masked by both enables
    function automatic rgb_t plane_bits(
        input pixel_t px,
        input plane_t plane,
        input rgb_t rgb_en,
        input logic [BRIGHTNESS_LEVELS-1:0] bright_en
    );
        rgb_t bits;
        bits = {px[11 + plane], px[6 + plane], px[plane]};
        return bits & rgb_en & {3{bright_en[plane]}};
    endfunction

    assign top_index = PIX_BITS'(fetch.row_address * PIXEL_WIDTH + fetch.column_address);
    assign rd_enable = fetch.load_start | bottom_pending;
    assign rd_address = bottom_pending ? bottom_index : top_index;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            bottom_pending <= 1'b0;
            top_ready <= 1'b0;
            fetch.data_valid <= 1'b0;
        end else begin
            bottom_pending <= fetch.load_start;
            top_ready <= bottom_pending;
            fetch.data_valid <= top_ready;
        end
    end

    always_ff @(posedge clk_in) begin
        bottom_index <= top_index + PIX_BITS'(HALF_OFFSET);
        if (bottom_pending)
            top_pixel <= rd_data;
        if (top_ready) begin
            fetch.rgb_top <= plane_bits(top_pixel, fetch.plane, rgb_enable, brightness_enable);
            fetch.rgb_bottom <= plane_bits(rd_data, fetch.plane, rgb_enable, brightness_enable);
        end
    end

endmodule

// ==== rtl/matrix_scan.sv ====
`timescale 1ns/1ps
module matrix_scan import hub75_pkg::*; #(
    parameter int PIXEL_WIDTH = hub75_pkg::PIXEL_WIDTH,
    parameter int PIXEL_HEIGHT = hub75_pkg::PIXEL_HEIGHT,
    parameter int SCAN_DIV = hub75_pkg::SCAN_DIV,
    parameter int OE_BASE_TICKS = hub75_pkg::OE_BASE_TICKS
) (
    input  logic clk_in,
    input  logic reset,
    fetch_if.scan scan,
    output rgb_t rgb_top,
    output rgb_t rgb_bottom,
    output logic clk_pixel,
    output logic row_latch,
    output logic output_enable,
    output logic [$clog2(PIXEL_HEIGHT / 2)-1:0] row_address
);
    localparam int COL_BITS = $clog2(PIXEL_WIDTH);
    localparam int ROW_BITS = $clog2(PIXEL_HEIGHT / 2);
    localparam int DIV_BITS = $clog2(SCAN_DIV);
    localparam int OE_BITS = $clog2((OE_BASE_TICKS << (BRIGHTNESS_LEVELS - 1)) + 1);
    localparam logic [COL_BITS-1:0] LAST_COLUMN = COL_BITS'(PIXEL_WIDTH - 1);
    localparam logic [ROW_BITS-1:0] LAST_ROW = ROW_BITS'(PIXEL_HEIGHT / 2 - 1);
    localparam logic [DIV_BITS-1:0] LAST_DIV = DIV_BITS'(SCAN_DIV - 1);
    localparam plane_t LAST_PLANE = plane_t'(BRIGHTNESS_LEVELS - 1);

    scan_state_t state;
    logic [DIV_BITS-1:0] div_count;
    logic tick;
    logic pending;    // load issued, pixel not back yet
    logic loaded;     // pins hold the pixel, clock edge still due
    logic [OE_BITS-1:0] oe_count;

    assign tick = (div_count == LAST_DIV);

    always_ff @(posedge clk_in) begin
        if (reset || tick)
            div_count <= '0;
        else
            div_count <= div_count + 1'b1;
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state <= SCAN_SHIFT;
            scan.column_address <= '0;
            scan.row_address <= '0;
            scan.plane <= '0;
            scan.load_start <= 1'b0;
            pending <= 1'b0;
            loaded <= 1'b0;
            oe_count <= '0;
            rgb_top <= '0;
            rgb_bottom <= '0;
            clk_pixel <= 1'b0;
            row_latch <= 1'b0;
            output_enable <= 1'b0;
            row_address <= '0;
        end else begin
            scan.load_start <= 1'b0;
            if (scan.data_valid) begin
                rgb_top <= scan.rgb_top;
                rgb_bottom <= scan.rgb_bottom;
                pending <= 1'b0;
                loaded <= 1'b1;
            end
            if (tick) begin
                case (state)
                    SCAN_SHIFT: begin
                        if (clk_pixel) begin
                            clk_pixel <= 1'b0;
                            if (scan.column_address == LAST_COLUMN) begin
                                scan.column_address <= '0;
                                row_latch <= 1'b1;
                                row_address <= scan.row_address;  // row just shifted in
                                state <= SCAN_LATCH;
                            end else begin
                                scan.column_address <= scan.column_address + 1'b1;
                            end
                        end else if (loaded) begin
                            clk_pixel <= 1'b1;  // panel shifts on this edge
                            loaded <= 1'b0;
                        end else if (!pending) begin
                            scan.load_start <= 1'b1;
                            pending <= 1'b1;
                        end
                    end
                    SCAN_LATCH: begin
                        row_latch <= 1'b0;
                        output_enable <= 1'b1;
                        // binary weighted on-time for the plane just latched
                        oe_count <= OE_BITS'((OE_BASE_TICKS << scan.plane) - 1);
                        state <= SCAN_DISPLAY;
                        if (scan.plane == LAST_PLANE) begin
                            scan.plane <= '0;
                            if (scan.row_address == LAST_ROW)
                                scan.row_address <= '0;
                            else
                                scan.row_address <= scan.row_address + 1'b1;
                        end else begin
                            scan.plane <= scan.plane + 1'b1;
                        end
                    end
                    default: begin
                        if (oe_count == '0) begin
                            output_enable <= 1'b0;
                            state <= SCAN_SHIFT;
                        end else begin
                            oe_count <= oe_count - 1'b1;
                        end
                    end
                endcase
            end
        end
    end

endmodule

// ==== rtl/hub75_top.sv ====
`timescale 1ns/1ps
module hub75_top import hub75_pkg::*; #(
    parameter int PIXEL_WIDTH = hub75_pkg::PIXEL_WIDTH,
    parameter int PIXEL_HEIGHT = hub75_pkg::PIXEL_HEIGHT,
    parameter int CTRL_TICKS_PER_BIT = hub75_pkg::CTRL_TICKS_PER_BIT,
    parameter int SCAN_DIV = hub75_pkg::SCAN_DIV,
    parameter int OE_BASE_TICKS = hub75_pkg::OE_BASE_TICKS
) (
    input  logic clk_in,
    input  logic reset,
    input  logic uart_rx_in,
    output rgb_t rgb_top,
    output rgb_t rgb_bottom,
    output logic clk_pixel,
    output logic row_latch,
    output logic output_enable_n,
    output logic [$clog2(PIXEL_HEIGHT / 2)-1:0] row_address
);
    localparam int PIXELS = PIXEL_WIDTH * PIXEL_HEIGHT;

    logic [7:0] rx_data;
    logic rx_valid;
    logic [$clog2(PIXELS * BYTES_PER_PIXEL)-1:0] wr_address;
    logic [7:0] wr_data;
    logic wr_enable;
    logic [$clog2(PIXELS)-1:0] rd_address;
    logic rd_enable;
    pixel_t rd_data;
    rgb_t rgb_enable;
    logic [BRIGHTNESS_LEVELS-1:0] brightness_enable;
    logic output_enable;

    fetch_if #(
        .PIXEL_WIDTH(PIXEL_WIDTH),
        .PIXEL_HEIGHT(PIXEL_HEIGHT)
    ) fetch_bus ();

    // host command path
    uart_rx #(
        .TICKS_PER_BIT(CTRL_TICKS_PER_BIT)
    ) u_uart_rx (
        .clk_in(clk_in),
        .reset(reset),
        .rx(uart_rx_in),
        .rx_data(rx_data),
        .rx_valid(rx_valid)
    );

    control_module #(
        .PIXEL_WIDTH(PIXEL_WIDTH),
        .PIXEL_HEIGHT(PIXEL_HEIGHT)
    ) u_ctrl (
        .clk_in(clk_in),
        .reset(reset),
        .rx_data(rx_data),
        .rx_valid(rx_valid),
        .wr_address(wr_address),
        .wr_data(wr_data),
        .wr_enable(wr_enable),
        .rgb_enable(rgb_enable),
        .brightness_enable(brightness_enable)
    );

    framebuffer_ram #(
        .PIXEL_WIDTH(PIXEL_WIDTH),
        .PIXEL_HEIGHT(PIXEL_HEIGHT)
    ) u_fb (
        .clk_in(clk_in),
        .wr_address(wr_address),
        .wr_data(wr_data),
        .wr_enable(wr_enable),
        .rd_address(rd_address),
        .rd_enable(rd_enable),
        .rd_data(rd_data)
    );

    framebuffer_fetch #(
        .PIXEL_WIDTH(PIXEL_WIDTH),
        .PIXEL_HEIGHT(PIXEL_HEIGHT)
    ) u_fetch (
        .clk_in(clk_in),
        .reset(reset),
        .fetch(fetch_bus.fetch),
        .rd_address(rd_address),
        .rd_enable(rd_enable),
        .rd_data(rd_data),
        .rgb_enable(rgb_enable),
        .brightness_enable(brightness_enable)
    );

    matrix_scan #(
        .PIXEL_WIDTH(PIXEL_WIDTH),
        .PIXEL_HEIGHT(PIXEL_HEIGHT),
        .SCAN_DIV(SCAN_DIV),
        .OE_BASE_TICKS(OE_BASE_TICKS)
    ) u_scan (
        .clk_in(clk_in),
        .reset(reset),
        .scan(fetch_bus.scan),
        .rgb_top(rgb_top),
        .rgb_bottom(rgb_bottom),
        .clk_pixel(clk_pixel),
        .row_latch(row_latch),
        .output_enable(output_enable),
        .row_address(row_address)
    );

    assign output_enable_n = ~output_enable;  // panel OE pin is active low

endmodule

// ==== sim/tb_clock.sv ====
`timescale 1ns/1ps
module tb_clock #(
    parameter int PERIOD_NS = 20
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(PERIOD_NS / 2) clk = ~clk;  // free running, even duty

endmodule

// ==== sim/tb_hub75.sv ====
`timescale 1ns/1ps
module tb_hub75 import hub75_pkg::*; ();

    localparam int CLK_PERIOD_NS = 20;
    localparam int DRIVE_DELAY_NS = 2;
    localparam int RESET_CYCLES = 8;
    localparam int FRAME_BYTES = PIXEL_WIDTH * PIXEL_HEIGHT * BYTES_PER_PIXEL;
    localparam int HALF_ROWS = PIXEL_HEIGHT / 2;
    localparam int PULSES_PER_FRAME = PIXEL_WIDTH * HALF_ROWS * BRIGHTNESS_LEVELS;
    localparam int CHECKED_FRAMES = 3;
    // four ticks per column, one latch tick, then the binary weighted on-time
    localparam int FRAME_TICKS = HALF_ROWS * (BRIGHTNESS_LEVELS * (4 * PIXEL_WIDTH + 1)
        + OE_BASE_TICKS * ((1 << BRIGHTNESS_LEVELS) - 1));
    localparam int LOAD_CLOCKS = (FRAME_BYTES + 2) * 10 * CTRL_TICKS_PER_BIT;
    localparam int CMD_CLOCKS = 16 * 10 * CTRL_TICKS_PER_BIT;
    // load and commands plus two scans per checked frame and two spare
    localparam int WATCHDOG_NS = (RESET_CYCLES + LOAD_CLOCKS + CMD_CLOCKS
        + (2 * CHECKED_FRAMES + 2) * FRAME_TICKS * SCAN_DIV) * CLK_PERIOD_NS;
    localparam logic [7:0] UNKNOWN_BYTE = 8'h55;

    logic clk;
    logic reset;
    logic uart_rx_in;
    rgb_t rgb_top;
    rgb_t rgb_bottom;
    logic clk_pixel;
    logic row_latch;
    logic output_enable_n;
    logic [$clog2(HALF_ROWS)-1:0] row_address;

    logic [7:0] frame_bytes [FRAME_BYTES];   // host side copy of the frame
    rgb_t exp_rgb_en;
    logic [BRIGHTNESS_LEVELS-1:0] exp_bright_en;
    logic check_on = 1'b0;
    logic clk_pixel_q;
    logic row_latch_q;
    logic oe_n_q;
    int col_count = 0;
    int row_trk = 0;
    int plane_trk = 0;
    int lit_plane = 0;    // plane shown during the current on-time
    int oe_clocks = 0;
    int frame_count = 0;
    int pixel_checks = 0;
    integer seed;

    tb_clock #(.PERIOD_NS(CLK_PERIOD_NS)) clock_gen (.clk(clk));

    hub75_top #(
        .PIXEL_WIDTH(PIXEL_WIDTH),
        .PIXEL_HEIGHT(PIXEL_HEIGHT),
        .CTRL_TICKS_PER_BIT(CTRL_TICKS_PER_BIT),
        .SCAN_DIV(SCAN_DIV),
        .OE_BASE_TICKS(OE_BASE_TICKS)
    ) dut0 (
        .clk_in(clk),
        .reset(reset),
        .uart_rx_in(uart_rx_in),
        .rgb_top(rgb_top),
        .rgb_bottom(rgb_bottom),
        .clk_pixel(clk_pixel),
        .row_latch(row_latch),
        .output_enable_n(output_enable_n),
        .row_address(row_address)
    );

    function automatic logic [15:0] model_pixel(input int row, input int column);
        int index;
        index = row * PIXEL_WIDTH + column;
        return {frame_bytes[2 * index], frame_bytes[2 * index + 1]};  // high byte first
    endfunction

    // plane index counts up from bits 11, 6 and 0
    function automatic rgb_t plane_color(input logic [15:0] px, input int plane,
            input rgb_t rgb_en, input logic [BRIGHTNESS_LEVELS-1:0] bright_en);
        rgb_t color;
        color[2] = 1'(px >> (11 + plane));
        color[1] = 1'(px >> (6 + plane));
        color[0] = 1'(px >> plane);
        if (1'(bright_en >> plane) == 1'b0)
            color = '0;  // plane blanked
        return color & rgb_en;
    endfunction

    function automatic logic [5:0] expected_pins(input int row, input int column,
            input int plane, input rgb_t rgb_en, input logic [BRIGHTNESS_LEVELS-1:0] bright_en);
        return {plane_color(model_pixel(row, column), plane, rgb_en, bright_en),
                plane_color(model_pixel(row + HALF_ROWS, column), plane, rgb_en, bright_en)};
    endfunction

    task automatic value_error(input string name, input logic [15:0] got,
            input logic [15:0] want);
        $display("[FAIL] %s = 0x%0h, expected 0x%0h", name, got, want);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_error(input string what);
        $display("ERROR: %s", what);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic drive_bit(input logic value);
        uart_rx_in = value;
        repeat (CTRL_TICKS_PER_BIT) @(posedge clk);
        #DRIVE_DELAY_NS;
    endtask

    task automatic send_byte(input logic [7:0] data);
        drive_bit(1'b0);  // start bit
        for (int i = 0; i < 8; i++)
            drive_bit(data[i]);
        drive_bit(1'b1);
    endtask

    task automatic load_random_frame();
        for (int k = 0; k < FRAME_BYTES; k++)
            frame_bytes[k] = 8'($random(seed));
        send_byte(OP_LOAD_FRAME);
        for (int k = 0; k < FRAME_BYTES; k++)
            send_byte(frame_bytes[k]);
        drive_bit(1'b1);  // idle line before the scan check
    endtask

    // outputs stay quiet from reset release up to the first scan tick
    task automatic check_idle_outputs();
        repeat (SCAN_DIV) begin
            assert (output_enable_n === 1'b1)
                else value_error("output_enable_n", 16'(output_enable_n), 16'h1);
            assert (clk_pixel === 1'b0)
                else value_error("clk_pixel", 16'(clk_pixel), 16'h0);
            assert (row_latch === 1'b0)
                else value_error("row_latch", 16'(row_latch), 16'h0);
            @(posedge clk);
            #DRIVE_DELAY_NS;
        end
    endtask

    task automatic check_next_frame();
        int target;
        target = frame_count + 1;
        wait (frame_count == target);  // scan is back at row 0, plane 0
        check_on = 1'b1;
        target = frame_count + 1;
        wait (frame_count == target);
        check_on = 1'b0;
    endtask

    always @(posedge clk) begin : compare
        logic [5:0] want;
        if (reset) begin
            col_count = 0;
            row_trk = 0;
            plane_trk = 0;
            lit_plane = 0;
            oe_clocks = 0;
            frame_count = 0;
            pixel_checks = 0;
        end else begin
            if (clk_pixel && !clk_pixel_q) begin
                if (check_on) begin
                    want = expected_pins(row_trk, col_count, plane_trk, exp_rgb_en,
                        exp_bright_en);
                    assert (rgb_top === want[5:3])
                        else value_error("rgb_top", 16'(rgb_top), 16'(want[5:3]));
                    assert (rgb_bottom === want[2:0])
                        else value_error("rgb_bottom", 16'(rgb_bottom), 16'(want[2:0]));
                    pixel_checks++;
                end
                col_count++;
            end
            if (row_latch && !row_latch_q) begin
                assert (col_count == PIXEL_WIDTH)
                    else check_error($sformatf("%0d clk_pixel pulses before row_latch, not %0d",
                        col_count, PIXEL_WIDTH));
                assert (int'(row_address) == row_trk)
                    else value_error("row_address", 16'(row_address), 16'(row_trk));
                col_count = 0;
                lit_plane = plane_trk;
                if (plane_trk == BRIGHTNESS_LEVELS - 1) begin
                    plane_trk = 0;
                    if (row_trk == HALF_ROWS - 1) begin
                        row_trk = 0;
                        frame_count++;  // whole frame scanned
                    end else begin
                        row_trk++;
                    end
                end else begin
                    plane_trk++;
                end
            end
            if (output_enable_n === 1'b0)
                oe_clocks++;
            if (output_enable_n && !oe_n_q) begin
                // on-time doubles with each plane
                assert (oe_clocks == (OE_BASE_TICKS << lit_plane) * SCAN_DIV)
                    else check_error($sformatf("plane %0d lit for %0d clocks, not %0d",
                        lit_plane, oe_clocks, (OE_BASE_TICKS << lit_plane) * SCAN_DIV));
                oe_clocks = 0;
            end
        end
        clk_pixel_q = clk_pixel;
        row_latch_q = row_latch;
        oe_n_q = output_enable_n;
    end

    initial begin : stimulus
        seed = 32'h6b7b_e41e;
        reset = 1'b1;
        uart_rx_in = 1'b1;  // uart line idles high
        exp_rgb_en = 3'b111;
        exp_bright_en = '1;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY_NS;
        reset = 1'b0;
        check_idle_outputs();

        load_random_frame();
        check_next_frame();

        // green channel disabled
        send_byte(OP_SET_RGB);
        send_byte(8'h05);
        exp_rgb_en = 3'b101;
        check_next_frame();

        // a stray byte in idle must not swallow the brightness opcode
        send_byte(OP_SET_RGB);
        send_byte(8'h07);
        send_byte(UNKNOWN_BYTE);
        send_byte(OP_SET_BRIGHTNESS);
        send_byte(8'h06);
        exp_rgb_en = 3'b111;
        exp_bright_en = 5'b00110;
        check_next_frame();

        assert (pixel_checks == CHECKED_FRAMES * PULSES_PER_FRAME)
            else check_error($sformatf("only %0d pixels were compared", pixel_checks));
        $display("PASS: all tests");
        $finish;
    end

    initial begin : watchdog
        #WATCHDOG_NS;
        check_error("watchdog timeout, the scan or the UART stalled");
    end

endmodule

// ==== filelist.f ====
rtl/hub75_pkg.sv
rtl/fetch_if.sv
rtl/uart_rx.sv
rtl/control_module.sv
rtl/framebuffer_ram.sv
rtl/framebuffer_fetch.sv
rtl/matrix_scan.sv
rtl/hub75_top.sv
sim/tb_clock.sv
sim/tb_hub75.sv

// ==== Makefile ====
TOP := tb_hub75

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		-f filelist.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "PASS: all tests"

clean:
	rm -rf obj_dir
